/* hdl/fetch_pkg.sv */
/*
  Shared types and constants for the RV32I instruction fetch subsystem.
  Every fetch module pulls these in with a wildcard import in its header.
  Change the reset vector, predictor depth or bus byte order here only.
*/

package fetch_pkg;

  // one instruction or address word
  typedef logic [31:0] word_t;

  // first fetch address after reset and after halt
  localparam word_t RESET_PC = 32'h8000_0000;

  // pc bits [BTB_INDEX_BITS+1:2] select the predictor entry
  // 4 bits gives 16 entries
  localparam int BTB_INDEX_BITS = 4;

  // everything above the index is kept as the tag
  // the low two bits are the byte offset and never stored
  localparam int BTB_TAG_BITS = 32 - BTB_INDEX_BITS - 2;

  // memory byte order on the instruction bus
  // 0 means little endian, so the returned word gets its bytes reversed
  localparam logic BUS_BIG_ENDIAN = 1'b0;

endpackage

/* hdl/pc_unit.sv */
/*
  Program counter for the fetch stage.
  Picks the next PC by redirect priority, drives the instruction bus request
  and keeps the predictor verdict that travels with each fetched word.
*/

`timescale 1ns/10ps

module pc_unit import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  halt,
  input  logic  pc_en,
  input  logic  stall_fetch_decode,
  input  logic  insert_priv_pc,
  input  logic  intr_taken,
  input  logic  csr_flush,
  input  logic  ifence_flush,
  input  logic  npc_sel,
  input  word_t priv_pc,
  input  word_t csr_pc,
  input  word_t ifence_pc,
  input  word_t brj_addr,
  input  word_t target_addr,
  input  logic  predict_taken,
  output word_t current_pc,
  output word_t pc4,
  output logic  imem_ren,
  output logic  prediction
);

  word_t next_pc;
  logic  advance;

  // sequential successor of the current fetch address
  assign pc4 = current_pc + 32'd4;

  // read every cycle unless the core is halted
  assign imem_ren = ~halt;

  // privileged insert overrides a stall
  assign advance = (pc_en & ~stall_fetch_decode) | insert_priv_pc;

  // next pc select, highest priority first
  always_comb begin
    if (insert_priv_pc) begin
      next_pc = priv_pc;
    end else if (intr_taken) begin
      // replay the current pc so the trap sees it
      next_pc = current_pc;
    end else if (csr_flush) begin
      next_pc = csr_pc + 32'd4;
    end else if (ifence_flush) begin
      next_pc = ifence_pc + 32'd4;
    end else if (npc_sel) begin
      // resolved branch or jump from execute
      next_pc = brj_addr;
    end else if (predict_taken) begin
      next_pc = target_addr;
    end else begin
      next_pc = pc4;
    end
  end

  // pc register
  // prediction is captured on the same edge the latch takes the old word,
  // so decode sees the verdict that was made for that word
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      current_pc <= RESET_PC;
      prediction <= 1'b0;
    end else if (halt) begin
      // restart point once halt drops
      current_pc <= RESET_PC;
      prediction <= 1'b0;
    end else if (advance) begin
      current_pc <= next_pc;
      prediction <= predict_taken;
    end
  end

endmodule

/* hdl/btb_predictor.sv */
/*
  Direct-mapped branch target buffer with two-bit saturating counters.
  Lookup is combinational on the fetch PC; training comes from resolved
  branches as a one-cycle strobe and is visible from the following cycle.
*/

`timescale 1ns/10ps

module btb_predictor import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  update_en,
  input  logic  update_taken,
  input  word_t current_pc,
  input  word_t update_pc,
  input  word_t update_target,
  output logic  predict_taken,
  output word_t target_addr
);

  localparam int ENTRIES = 2 ** BTB_INDEX_BITS;

  // counter encodings
  localparam logic [1:0] CNT_STRONG_NT = 2'b00;
  localparam logic [1:0] CNT_WEAK_T    = 2'b10;
  localparam logic [1:0] CNT_STRONG_T  = 2'b11;

  logic [ENTRIES-1:0]      valid;
  logic [BTB_TAG_BITS-1:0] tags    [ENTRIES];
  word_t                   targets [ENTRIES];
  logic [1:0]              counters[ENTRIES];

  logic [BTB_INDEX_BITS-1:0] lookup_idx;
  logic [BTB_TAG_BITS-1:0]   lookup_tag;
  logic [BTB_INDEX_BITS-1:0] upd_idx;
  logic [BTB_TAG_BITS-1:0]   upd_tag;
  logic                      lookup_hit;
  logic                      upd_hit;

  // split pc into index and tag above the byte offset
  assign lookup_idx = current_pc[BTB_INDEX_BITS+1:2];
  assign lookup_tag = current_pc[31:BTB_INDEX_BITS+2];
  assign upd_idx    = update_pc[BTB_INDEX_BITS+1:2];
  assign upd_tag    = update_pc[31:BTB_INDEX_BITS+2];

  // lookup side
  assign lookup_hit    = valid[lookup_idx] && (tags[lookup_idx] == lookup_tag);
  // taken only on a hit with counter msb set
  assign predict_taken = lookup_hit && counters[lookup_idx][1];
  assign target_addr   = targets[lookup_idx];

  // training side
  assign upd_hit = valid[upd_idx] && (tags[upd_idx] == upd_tag);

  // valid bits per entry
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (update_en && update_taken && !upd_hit) begin
      // allocate on a taken miss
      valid[upd_idx] <= 1'b1;
    end
  end

  // entry contents
  always_ff @(posedge CLK) begin
    if (update_en) begin
      if (upd_hit) begin
        // train existing entry and refresh its target either way
        targets[upd_idx] <= update_target;
        if (update_taken) begin
          if (counters[upd_idx] != CNT_STRONG_T) begin
            counters[upd_idx] <= counters[upd_idx] + 2'd1;
          end
        end else begin
          if (counters[upd_idx] != CNT_STRONG_NT) begin
            counters[upd_idx] <= counters[upd_idx] - 2'd1;
          end
        end
      end else if (update_taken) begin
        // new entry starts weakly taken
        tags[upd_idx]     <= upd_tag;
        targets[upd_idx]  <= update_target;
        counters[upd_idx] <= CNT_WEAK_T;
      end
      // not-taken miss leaves the table alone
    end
  end

endmodule

/* hdl/fetch_decode_latch.sv */
/*
  Fetch to decode pipeline register.
  Takes the word returned for the current PC, puts it in processor byte
  order, flags a misaligned fetch and applies halt, flush, bubble and stall.
*/

`timescale 1ns/10ps

module fetch_decode_latch import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  halt,
  input  logic  pc_en,
  input  logic  stall_fetch_decode,
  input  logic  if_id_flush,
  input  word_t fetch_pc,
  input  word_t fetch_pc4,
  input  word_t imem_rdata,
  output logic  token,
  output logic  mal_insn,
  output word_t pc,
  output word_t pc4,
  output word_t instr
);

  word_t fetch_instr;
  logic  fetch_mal;
  logic  bubble;
  logic  capture;

  // byte order fixup
  always_comb begin
    if (BUS_BIG_ENDIAN) begin
      fetch_instr = imem_rdata;
    end else begin
      // reverse the four bytes
      fetch_instr = {imem_rdata[7:0], imem_rdata[15:8],
                     imem_rdata[23:16], imem_rdata[31:24]};
    end
  end

  // instructions are word aligned in rv32i without C
  assign fetch_mal = (fetch_pc[1:0] != 2'b00);

  // flush, or pc held with no stall, sends an empty slot
  assign bubble  = if_id_flush | (~pc_en & ~stall_fetch_decode);
  assign capture = pc_en & ~stall_fetch_decode;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      token    <= 1'b0;
      mal_insn <= 1'b0;
      pc       <= '0;
      pc4      <= '0;
      instr    <= '0;
    end else if (halt) begin
      // instr left as is, token already marks it dead
      token    <= 1'b0;
      mal_insn <= 1'b0;
      pc       <= '0;
      pc4      <= '0;
    end else if (bubble) begin
      // pc and pc4 kept
      token    <= 1'b0;
      mal_insn <= 1'b0;
      instr    <= '0;
    end else if (capture) begin
      token    <= 1'b1;
      mal_insn <= fetch_mal;
      pc       <= fetch_pc;
      pc4      <= fetch_pc4;
      instr    <= fetch_instr;
    end
    // stall holds everything
  end

endmodule

/* hdl/fetch_top.sv */
/*
  Instruction fetch subsystem top level.
  Ties the program counter, branch target buffer and fetch/decode register
  to the instruction bus, the hazard controls and the decode outputs.
*/

`timescale 1ns/10ps

module fetch_top import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  // hazard and redirect controls
  input  logic  halt,
  input  logic  pc_en,
  input  logic  stall_fetch_decode,
  input  logic  if_id_flush,
  input  logic  insert_priv_pc,
  input  word_t priv_pc,
  input  logic  intr_taken,
  input  logic  csr_flush,
  input  word_t csr_pc,
  input  logic  ifence_flush,
  input  word_t ifence_pc,
  input  logic  npc_sel,
  input  word_t brj_addr,
  // predictor training from execute
  input  logic  update_en,
  input  logic  update_taken,
  input  word_t update_pc,
  input  word_t update_target,
  // instruction bus
  input  word_t imem_rdata,
  input  logic  imem_busy,
  output word_t imem_addr,
  output logic  imem_ren,
  output logic  i_mem_busy,
  // to decode
  output logic  token,
  output word_t pc,
  output word_t pc4,
  output word_t instr,
  output logic  mal_insn,
  output logic  prediction
);

  word_t current_pc;
  word_t next_seq_pc;
  word_t target_addr;
  logic  predict_taken;

  // bus busy goes straight out to the hazard unit
  assign i_mem_busy = imem_busy;
  assign imem_addr  = current_pc;

  pc_unit u_pc_unit (
    .CLK                (CLK),
    .nRST               (nRST),
    .halt               (halt),
    .pc_en              (pc_en),
    .stall_fetch_decode (stall_fetch_decode),
    .insert_priv_pc     (insert_priv_pc),
    .intr_taken         (intr_taken),
    .csr_flush          (csr_flush),
    .ifence_flush       (ifence_flush),
    .npc_sel            (npc_sel),
    .priv_pc            (priv_pc),
    .csr_pc             (csr_pc),
    .ifence_pc          (ifence_pc),
    .brj_addr           (brj_addr),
    .target_addr        (target_addr),
    .predict_taken      (predict_taken),
    .current_pc         (current_pc),
    .pc4                (next_seq_pc),
    .imem_ren           (imem_ren),
    .prediction         (prediction)
  );

  // lookup is on the address being fetched now
  btb_predictor u_btb_predictor (
    .CLK           (CLK),
    .nRST          (nRST),
    .update_en     (update_en),
    .update_taken  (update_taken),
    .current_pc    (current_pc),
    .update_pc     (update_pc),
    .update_target (update_target),
    .predict_taken (predict_taken),
    .target_addr   (target_addr)
  );

  fetch_decode_latch u_fetch_decode_latch (
    .CLK                (CLK),
    .nRST               (nRST),
    .halt               (halt),
    .pc_en              (pc_en),
    .stall_fetch_decode (stall_fetch_decode),
    .if_id_flush        (if_id_flush),
    .fetch_pc           (current_pc),
    .fetch_pc4          (next_seq_pc),
    .imem_rdata         (imem_rdata),
    .token              (token),
    .mal_insn           (mal_insn),
    .pc                 (pc),
    .pc4                (pc4),
    .instr              (instr)
  );

endmodule

/* verification/tb_fetch_top.sv */
/*
  Directed testbench for the fetch subsystem top level.
  A hashed instruction memory answers the bus; each test task drives the
  controls, checks decode outputs and prints one result line.
*/

`timescale 1ns/10ps

module tb_fetch_top import fetch_pkg::*; ();

  localparam int    CLK_PERIOD      = 20;
  localparam int    NUM_TESTS       = 6;
  localparam int    CYCLES_PER_TEST = 200;
  localparam int    TOKEN_WAIT      = 10;
  localparam word_t LCG_SEED        = 32'h4113;

  // addresses used by the directed tests
  localparam word_t PRIV_ADDR   = 32'h8000_0200;
  localparam word_t CSR_ADDR    = 32'h8000_0300;
  localparam word_t IFENCE_ADDR = 32'h8000_0400;
  localparam word_t BRJ_ADDR    = 32'h8000_0500;
  // branch at X with a tag unlike every other address here
  localparam word_t BR_X        = 32'h8000_1040;
  localparam word_t BR_T        = 32'h8000_2000;

  logic  CLK, nRST;
  // hazard and redirect controls
  logic  halt, pc_en, stall_fetch_decode, if_id_flush;
  logic  insert_priv_pc, intr_taken, csr_flush, ifence_flush, npc_sel;
  word_t priv_pc, csr_pc, ifence_pc, brj_addr;
  // predictor training
  logic  update_en, update_taken;
  word_t update_pc, update_target;
  // instruction bus
  word_t imem_rdata, imem_addr;
  logic  imem_busy, imem_ren, i_mem_busy;
  // decode side
  logic  token, mal_insn, prediction;
  word_t pc, pc4, instr;

  int checks, errors, tests_run, tests_failed, test_start_errors;

  fetch_top dut (.*);

  function automatic word_t lcg_next(word_t state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // memory word in bus byte order from two lcg rounds over the full address
  function automatic word_t mem_hash(word_t addr);
    return lcg_next(lcg_next(LCG_SEED ^ addr));
  endfunction

  // what decode should see for a given fetch address
  function automatic word_t expected_instr(word_t addr);
    word_t raw;
    raw = mem_hash(addr);
    if (BUS_BIG_ENDIAN) begin
      return raw;
    end
    return {raw[7:0], raw[15:8], raw[23:16], raw[31:24]};
  endfunction

  // combinational memory
  assign imem_rdata = imem_ren ? mem_hash(imem_addr) : 32'd0;

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  task automatic compare_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == test_start_errors) begin
      $display("[%0t] %s: ok", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t] %s: FAILED, %0d mismatches", $time, name, errors - test_start_errors);
    end
  endtask

  // polls at falling edges until decode holds a valid slot
  task automatic wait_token();
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (!token && cycles < TOKEN_WAIT) begin
      @(negedge CLK);
      cycles++;
    end
    if (!token) begin
      errors++;
      $display("Error at %0t: decode token did not rise within %0d cycles", $time, TOKEN_WAIT);
    end
  endtask

  // privileged insert with fetch idle so decode gets a bubble
  task automatic set_pc(input word_t target);
    @(posedge CLK);
    pc_en          <= 1'b0;
    insert_priv_pc <= 1'b1;
    priv_pc        <= target;
    @(posedge CLK);
    insert_priv_pc <= 1'b0;
    @(negedge CLK);
    compare_word("imem_addr", target, imem_addr);
  endtask

  task automatic start_fetch();
    @(posedge CLK);
    pc_en <= 1'b1;
    wait_token();
  endtask

  task automatic stop_fetch();
    @(posedge CLK);
    pc_en <= 1'b0;
  endtask

  task automatic check_decode(input word_t exp_pc);
    compare_bit("token", 1'b1, token);
    compare_word("pc", exp_pc, pc);
    compare_word("pc4", exp_pc + 32'd4, pc4);
    compare_word("instr", expected_instr(exp_pc), instr);
    compare_bit("mal_insn", exp_pc[1:0] != 2'b00, mal_insn);
  endtask

  // sel is {priv, intr, csr, ifence, npc} held for one edge
  task automatic redirect_case(input logic [4:0] sel, input logic stall, input word_t expected);
    @(posedge CLK);
    pc_en              <= 1'b1;
    stall_fetch_decode <= stall;
    priv_pc            <= PRIV_ADDR;
    {insert_priv_pc, intr_taken, csr_flush, ifence_flush, npc_sel} <= sel;
    @(posedge CLK);
    pc_en              <= 1'b0;
    stall_fetch_decode <= 1'b0;
    {insert_priv_pc, intr_taken, csr_flush, ifence_flush, npc_sel} <= 5'b0;
    @(negedge CLK);
    compare_word("imem_addr", expected, imem_addr);
  endtask

  // update strobe held for the given number of edges
  task automatic train_btb(input word_t br_pc, input word_t target, input logic taken,
                           input int cycles);
    @(posedge CLK);
    update_en     <= 1'b1;
    update_pc     <= br_pc;
    update_target <= target;
    update_taken  <= taken;
    repeat (cycles) @(posedge CLK);
    update_en <= 1'b0;
  endtask

  task automatic reset_and_sequential();
    word_t addr;
    test_start_errors = errors;
    compare_bit("token", 1'b0, token);
    compare_bit("prediction", 1'b0, prediction);
    compare_bit("imem_ren", 1'b1, imem_ren);
    compare_word("imem_addr", RESET_PC, imem_addr);
    addr = RESET_PC;
    start_fetch();
    repeat (8) begin
      check_decode(addr);
      compare_word("imem_addr", addr + 32'd4, imem_addr);
      addr = addr + 32'd4;
      @(negedge CLK);
    end
    stop_fetch();
    report_test("reset_and_sequential");
  endtask

  task automatic stall_and_bubble();
    word_t base;
    test_start_errors = errors;
    base = 32'h8000_0100;
    set_pc(base);
    start_fetch();
    check_decode(base);
    // the edge that raises stall still advances once
    @(posedge CLK);
    stall_fetch_decode <= 1'b1;
    imem_busy          <= 1'b1;
    repeat (4) begin
      @(negedge CLK);
      check_decode(base + 32'd4);
      compare_word("imem_addr", base + 32'd8, imem_addr);
    end
    compare_bit("i_mem_busy", 1'b1, i_mem_busy);
    @(posedge CLK);
    stall_fetch_decode <= 1'b0;
    imem_busy          <= 1'b0;
    pc_en              <= 1'b0;
    @(negedge CLK);
    check_decode(base + 32'd4);
    compare_bit("i_mem_busy", 1'b0, i_mem_busy);
    // bubble keeps pc and empties the slot
    repeat (2) begin
      @(negedge CLK);
      compare_bit("token", 1'b0, token);
      compare_word("instr", 32'd0, instr);
      compare_word("pc", base + 32'd4, pc);
      compare_word("imem_addr", base + 32'd8, imem_addr);
    end
    start_fetch();
    check_decode(base + 32'd8);
    compare_word("imem_addr", base + 32'd12, imem_addr);
    // one flushed edge empties the slot and keeps the decode pc
    @(posedge CLK);
    if_id_flush <= 1'b1;
    @(negedge CLK);
    check_decode(base + 32'd12);
    @(posedge CLK);
    if_id_flush <= 1'b0;
    @(negedge CLK);
    compare_bit("token", 1'b0, token);
    compare_word("instr", 32'd0, instr);
    compare_word("pc", base + 32'd12, pc);
    stop_fetch();
    report_test("stall_and_bubble");
  endtask

  task automatic redirect_priority();
    test_start_errors = errors;
    set_pc(32'h8000_0600);
    @(posedge CLK);
    csr_pc    <= CSR_ADDR;
    ifence_pc <= IFENCE_ADDR;
    brj_addr  <= BRJ_ADDR;
    redirect_case(5'b11111, 1'b0, PRIV_ADDR);
    redirect_case(5'b00111, 1'b0, CSR_ADDR + 32'd4);
    redirect_case(5'b00011, 1'b0, IFENCE_ADDR + 32'd4);
    // interrupt replays the pc it stands on
    redirect_case(5'b01111, 1'b0, IFENCE_ADDR + 32'd4);
    redirect_case(5'b00001, 1'b0, BRJ_ADDR);
    redirect_case(5'b00101, 1'b0, CSR_ADDR + 32'd4);
    redirect_case(5'b00000, 1'b0, CSR_ADDR + 32'd8);
    // insert gets through a stall but a branch does not
    redirect_case(5'b10000, 1'b1, PRIV_ADDR);
    redirect_case(5'b00001, 1'b1, PRIV_ADDR);
    report_test("redirect_priority");
  endtask

  task automatic branch_prediction();
    test_start_errors = errors;
    train_btb(BR_X, BR_T, 1'b1, 1);
    set_pc(BR_X);
    start_fetch();
    check_decode(BR_X);
    compare_bit("prediction", 1'b1, prediction);
    compare_word("imem_addr", BR_T, imem_addr);
    @(negedge CLK);
    check_decode(BR_T);
    compare_bit("prediction", 1'b0, prediction);
    stop_fetch();
    // weakly taken drops to not taken after two misses
    train_btb(BR_X, BR_T, 1'b0, 2);
    set_pc(BR_X);
    start_fetch();
    check_decode(BR_X);
    compare_bit("prediction", 1'b0, prediction);
    compare_word("imem_addr", BR_X + 32'd4, imem_addr);
    stop_fetch();
    report_test("branch_prediction");
  endtask

  task automatic misaligned_fetch();
    test_start_errors = errors;
    set_pc(32'h8000_0702);
    start_fetch();
    check_decode(32'h8000_0702);
    stop_fetch();
    set_pc(32'h8000_0800);
    start_fetch();
    check_decode(32'h8000_0800);
    stop_fetch();
    report_test("misaligned_fetch");
  endtask

  task automatic halt_and_restart();
    test_start_errors = errors;
    // misaligned start so halt has a set mal_insn to clear
    set_pc(32'h8000_0902);
    start_fetch();
    check_decode(32'h8000_0902);
    @(posedge CLK);
    halt <= 1'b1;
    // read enable drops right away
    @(negedge CLK);
    compare_bit("imem_ren", 1'b0, imem_ren);
    repeat (3) begin
      @(negedge CLK);
      compare_bit("imem_ren", 1'b0, imem_ren);
      compare_bit("token", 1'b0, token);
      compare_bit("mal_insn", 1'b0, mal_insn);
      compare_word("imem_addr", RESET_PC, imem_addr);
      compare_word("pc", 32'd0, pc);
      compare_word("pc4", 32'd0, pc4);
    end
    @(posedge CLK);
    halt <= 1'b0;
    wait_token();
    check_decode(RESET_PC);
    compare_bit("imem_ren", 1'b1, imem_ren);
    compare_word("imem_addr", RESET_PC + 32'd4, imem_addr);
    @(negedge CLK);
    check_decode(RESET_PC + 32'd4);
    stop_fetch();
    report_test("halt_and_restart");
  endtask

  // watchdog sized from the test count
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Error at %0t: watchdog expired before the tests finished", $time);
    $display("Test failures found");
    $finish;
  end

  initial begin
    nRST = 1'b0;
    {halt, pc_en, stall_fetch_decode, if_id_flush} = 4'b0;
    {insert_priv_pc, intr_taken, csr_flush, ifence_flush, npc_sel} = 5'b0;
    {priv_pc, csr_pc, ifence_pc, brj_addr} = '0;
    {update_en, update_taken, imem_busy} = 3'b0;
    {update_pc, update_target} = '0;
    {checks, errors, tests_run, tests_failed, test_start_errors} = '0;
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    reset_and_sequential();
    stall_and_bubble();
    redirect_priority();
    branch_prediction();
    misaligned_fetch();
    halt_and_restart();
    $display("tests run %0d, failed %0d, checks %0d, mismatches %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* fetch_pipe.f */
hdl/fetch_pkg.sv
hdl/pc_unit.sv
hdl/btb_predictor.sv
hdl/fetch_decode_latch.sv
hdl/fetch_top.sv
verification/tb_fetch_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the fetch testbench with verilator, run it and scan the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_fetch

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_fetch_top -o "$BIN" -f fetch_pipe.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
  exit 0
fi
echo "simulation log reports failures"
exit 1
